// ==== files.f ====
verilog/bn_act_pkg.sv
verilog/sdp_ram.sv
verilog/bn_calc_pipe.sv
verilog/res_fifo.sv
verilog/bn_act_top.sv
verif/bn_act_properties.sv
verif/bn_act_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the BN stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module bn_act_tb -f files.f -o bn_act_sim

# keep the output even when the simulation stops on an assertion
out=$(./obj_dir/bn_act_sim) || true
echo "$out"

echo "$out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'

// ==== verif/bn_act_properties.sv ====
////////////////////////////////////////
// stream rules checked on bn_act_top
// stall limit is FIFO_DEPTH plus PIPE_LAT
////////////////////////////////////////
`timescale 1ns/1ps

module bn_act_properties #(
	parameter int FIFO_DEPTH = 16
)(
	input logic aclk,
	input logic rst_n_i,
	input logic s_valid_i,
	input logic s_ready_i,
	input logic m_valid_i,
	input bn_act_pkg::data_t m_data_i,
	input logic m_last_i,
	input logic m_ready_i
);

	localparam int STALL_LIM = FIFO_DEPTH + bn_act_pkg::PIPE_LAT;

	int stall_cnt; // output blocked with input offered

	always_ff @(posedge aclk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			stall_cnt <= 0;
		else if (!m_ready_i && s_valid_i)
			stall_cnt <= (stall_cnt < STALL_LIM) ? stall_cnt + 1 : stall_cnt; // saturates
		else
			stall_cnt <= 0;
	end

	hold_stable: assert property (@(posedge aclk) disable iff (!rst_n_i)
		m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i) && $stable(m_last_i))
		else $error("output dropped or changed while stalled");

	idle_in_reset: assert property (@(posedge aclk) !rst_n_i |-> !m_valid_i)
		else $error("output valid during reset");

	full_stops_input: assert property (@(posedge aclk) disable iff (!rst_n_i)
		stall_cnt >= STALL_LIM |-> !s_ready_i)
		else $error("input still ready after a long output stall");

endmodule

bind bn_act_top bn_act_properties #(
	.FIFO_DEPTH(FIFO_DEPTH)
) bn_act_properties_inst (
	.aclk(aclk),
	.rst_n_i(rst_n_i),
	.s_valid_i(s_valid_i),
	.s_ready_i(s_ready_o),
	.m_valid_i(m_valid_o),
	.m_data_i(m_data_o),
	.m_last_i(m_last_o),
	.m_ready_i(m_ready_i)
);

// ==== verif/bn_act_tb.sv ====
////////////////////////////////////////
// random traffic through bn_act_top, checked against a scoreboard queue
// parameter table covers channels 0 to 15 only
////////////////////////////////////////
`timescale 1ns/1ps

module bn_act_tb;

	localparam int MAX_CHN_N = 1024;
	localparam int FIFO_DEPTH = 16;
	localparam int N_GEN = 200;
	localparam int N_FLAG = 60;
	localparam int N_BP = 120;
	// table load, items per test with back-pressure at a third of the rate, drains
	localparam int TEST_CYCLES = 16 + N_GEN + 2 * N_FLAG + 3 * N_BP + 5 * 40;
	localparam int RUN_LIMIT = 2 * TEST_CYCLES + 200;

	logic aclk = 1'b0;
	logic rst_n_i;
	logic bn_wen_i;
	logic [$clog2(MAX_CHN_N)-1:0] bn_waddr_i;
	bn_act_pkg::bn_param_t bn_wdata_i;
	logic [bn_act_pkg::ACCRC_W-1:0] bn_accrc_i;
	logic bn_a_eq_1_i;
	logic bn_b_eq_0_i;
	logic s_valid_i;
	bn_act_pkg::data_t s_data_i;
	logic [bn_act_pkg::CHN_W-1:0] s_chn_i;
	logic s_last_i;
	logic s_ready_o;
	logic m_valid_o;
	bn_act_pkg::data_t m_data_o;
	logic m_last_o;
	logic m_ready_i;

	integer seed;
	int cycle_cnt = 0;
	int chk_cnt = 0;
	int stim_err = 0; // errors found by the stimulus process
	int sb_err = 0; // errors found by the scoreboard
	bn_act_pkg::data_t prm_a [16]; // copy of the table
	bn_act_pkg::data_t prm_b [16];
	bn_act_pkg::fifo_entry_t exp_q [$];
	bn_act_pkg::fifo_entry_t exp_e;

	bn_act_top #(
		.MAX_CHN_N(MAX_CHN_N),
		.FIFO_DEPTH(FIFO_DEPTH)
	) bn_act_top_inst (
		.aclk(aclk),
		.rst_n_i(rst_n_i),
		.bn_wen_i(bn_wen_i),
		.bn_waddr_i(bn_waddr_i),
		.bn_wdata_i(bn_wdata_i),
		.bn_accrc_i(bn_accrc_i),
		.bn_a_eq_1_i(bn_a_eq_1_i),
		.bn_b_eq_0_i(bn_b_eq_0_i),
		.s_valid_i(s_valid_i),
		.s_data_i(s_data_i),
		.s_chn_i(s_chn_i),
		.s_last_i(s_last_i),
		.s_ready_o(s_ready_o),
		.m_valid_o(m_valid_o),
		.m_data_o(m_data_o),
		.m_last_o(m_last_o),
		.m_ready_i(m_ready_i)
	);

	always #2 aclk = ~aclk; // 4 ns period

	function automatic logic signed [63:0] widen(input bn_act_pkg::data_t v);
		return {{32{v[31]}}, v};
	endfunction

	// expected y = ((x * A) >>> accrc) + B in 32 bits
	function automatic bn_act_pkg::data_t calc_expected(input bn_act_pkg::data_t x,
		input logic [3:0] chn);
		logic signed [63:0] prod;
		bn_act_pkg::data_t b;
		if (bn_a_eq_1_i)
			prod = widen(x);
		else
			prod = (widen(x) * widen(prm_a[chn])) >>> bn_accrc_i;
		b = bn_b_eq_0_i ? '0 : prm_b[chn];
		return prod[31:0] + b;
	endfunction

	function automatic logic rand_bit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic int errors();
		return stim_err + sb_err;
	endfunction

	// push on input transfer, compare on output transfer
	always @(posedge aclk)
	begin
		if (rst_n_i && s_valid_i && s_ready_o)
		begin
			exp_e.last = s_last_i;
			exp_e.data = calc_expected(s_data_i, s_chn_i[3:0]);
			exp_q.push_back(exp_e);
		end
		if (rst_n_i && m_valid_o && m_ready_i)
		begin
			chk_cnt++;
			assert (exp_q.size() != 0)
			else
			begin
				$display("output transfer arrived with no item in flight");
				sb_err++;
			end
			if (exp_q.size() != 0)
			begin
				exp_e = exp_q.pop_front();
				assert (m_data_o == exp_e.data)
				else
				begin
					$display("FAILED m_data_o expected %h actual %h", exp_e.data, m_data_o);
					sb_err++;
				end
				assert (m_last_o == exp_e.last)
				else
				begin
					$display("FAILED m_last_o expected %h actual %h", exp_e.last, m_last_o);
					sb_err++;
				end
			end
		end
	end

	always @(posedge aclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= RUN_LIMIT)
		begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic load_table();
		bn_act_pkg::data_t a;
		bn_act_pkg::data_t b;
		for (int ch = 0; ch < 16; ch++)
		begin
			a = $random(seed);
			b = $random(seed);
			prm_a[ch] = a;
			prm_b[ch] = b;
			bn_wen_i <= 1'b1;
			bn_waddr_i <= 10'(ch);
			bn_wdata_i.a <= a;
			bn_wdata_i.b <= b;
			@(posedge aclk);
		end
		bn_wen_i <= 1'b0;
	endtask

	task automatic configure(input logic a_eq_1, input logic b_eq_0);
		bn_a_eq_1_i <= a_eq_1;
		bn_b_eq_0_i <= b_eq_0;
		bn_accrc_i <= 5'($random(seed));
		m_ready_i <= 1'b1;
		@(posedge aclk);
	endtask

	task automatic drive_item();
		logic [3:0] chn;
		chn = 4'($random(seed));
		s_valid_i <= 1'b1;
		s_data_i <= $random(seed);
		s_chn_i <= {6'd0, chn};
		s_last_i <= rand_bit();
	endtask

	// returns on the edge where the offered item transfers
	task automatic wait_accept(input logic rand_rdy);
		do
		begin
			if (rand_rdy)
				m_ready_i <= rand_bit();
			@(posedge aclk);
		end
		while (!s_ready_o);
	endtask

	task automatic send_items(input int n, input logic rand_rdy);
		for (int i = 0; i < n; i++)
		begin
			drive_item();
			wait_accept(rand_rdy);
		end
		s_valid_i <= 1'b0;
	endtask

	task automatic wait_drain(input logic rand_rdy);
		do
		begin
			if (rand_rdy)
				m_ready_i <= rand_bit();
			@(posedge aclk);
		end
		while (exp_q.size() != 0);
		m_ready_i <= 1'b1;
	endtask

	task automatic report_test(input int num, input string name, input int n, input int err0);
		$display("test %0d %s: %0d items, %0d errors", num, name, n, errors() - err0);
	endtask

	initial
	begin
		int err0;
		int accepted;
		logic dropped;
		seed = 8190;
		rst_n_i = 1'b0;
		bn_wen_i = 1'b0;
		bn_waddr_i = '0;
		bn_wdata_i = '0;
		bn_accrc_i = '0;
		bn_a_eq_1_i = 1'b0;
		bn_b_eq_0_i = 1'b0;
		s_valid_i = 1'b0;
		s_data_i = '0;
		s_chn_i = '0;
		s_last_i = 1'b0;
		m_ready_i = 1'b0;
		repeat (3) @(posedge aclk);
		rst_n_i <= 1'b1;
		@(posedge aclk);

		err0 = errors();
		assert (!m_valid_o)
		else
		begin
			$display("FAILED m_valid_o expected %h actual %h", 1'b0, m_valid_o);
			stim_err++;
		end
		assert (s_ready_o)
		else
		begin
			$display("FAILED s_ready_o expected %h actual %h", 1'b1, s_ready_o);
			stim_err++;
		end
		report_test(1, "reset state", 0, err0);
		load_table();

		err0 = errors();
		configure(1'b0, 1'b0);
		send_items(N_GEN, 1'b0);
		wait_drain(1'b0);
		report_test(2, "general formula", N_GEN, err0);

		err0 = errors();
		configure(1'b1, 1'b0);
		send_items(N_FLAG, 1'b0);
		wait_drain(1'b0);
		report_test(3, "A equals one", N_FLAG, err0);

		err0 = errors();
		configure(1'b0, 1'b1);
		send_items(N_FLAG, 1'b0);
		wait_drain(1'b0);
		report_test(4, "B equals zero", N_FLAG, err0);

		err0 = errors();
		configure(1'b0, 1'b0);
		m_ready_i <= 1'b0;
		accepted = 0;
		dropped = 1'b0;
		while (!dropped && accepted <= FIFO_DEPTH)
		begin
			drive_item();
			@(posedge aclk);
			if (s_ready_o)
				accepted++;
			else
				dropped = 1'b1;
		end
		assert (dropped && accepted <= FIFO_DEPTH)
		else
		begin
			$display("s_ready_o stayed high for %0d items with the output stalled", accepted);
			stim_err++;
		end
		// input must stay blocked while the output is held
		repeat (bn_act_pkg::PIPE_LAT + 4)
		begin
			@(posedge aclk);
			assert (!s_ready_o)
			else
			begin
				$display("FAILED s_ready_o expected %h actual %h", 1'b0, s_ready_o);
				stim_err++;
			end
		end
		if (dropped)
			wait_accept(1'b1); // finish the item left on offer
		send_items(N_BP, 1'b1);
		wait_drain(1'b1);
		report_test(5, "back-pressure", accepted + 32'(dropped) + N_BP, err0);

		$display("5 tests, %0d outputs checked, %0d errors", chk_cnt, errors());
		if (errors() == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verilog/bn_act_pkg.sv ====
////////////////////////////////////////
// widths and payload types of the BN stage
// PIPE_LAT must track the register stages of bn_calc_pipe
// CHN_W bounds the depth of the parameter table
////////////////////////////////////////
package bn_act_pkg;

	localparam int DATA_W = 32; // result value and each BN parameter
	localparam int PROD_W = 64; // full signed product
	localparam int ACCRC_W = 5; // quantization accuracy, shift 0 to 31
	localparam int CHN_W = 10; // output channel number
	localparam int PIPE_LAT = 4; // acceptance to FIFO write

	// signed result value
	typedef logic signed [DATA_W-1:0] data_t;

	// one table word, laid out as {B, A}
	typedef struct packed
	{
		data_t b;
		data_t a;
	} bn_param_t;

	// one result FIFO word
	typedef struct packed
	{
		logic last;
		data_t data;
	} fifo_entry_t;

endpackage

// ==== verilog/bn_act_top.sv ====
////////////////////////////////////////
// MAX_CHN_N must not exceed 2**CHN_W
// write a channel's pair before items of that channel arrive
////////////////////////////////////////
`timescale 1ns/1ps

module bn_act_top #(
	parameter int MAX_CHN_N = 1024,
	parameter int FIFO_DEPTH = 16
)(
	input logic aclk,
	input logic rst_n_i,

	// parameter table write
	input logic bn_wen_i,
	input logic [$clog2(MAX_CHN_N)-1:0] bn_waddr_i,
	input bn_act_pkg::bn_param_t bn_wdata_i,

	// static configuration
	input logic [bn_act_pkg::ACCRC_W-1:0] bn_accrc_i,
	input logic bn_a_eq_1_i,
	input logic bn_b_eq_0_i,

	// input stream
	input logic s_valid_i,
	input bn_act_pkg::data_t s_data_i,
	input logic [bn_act_pkg::CHN_W-1:0] s_chn_i,
	input logic s_last_i,
	output logic s_ready_o,

	// output stream
	output logic m_valid_o,
	output bn_act_pkg::data_t m_data_o,
	output logic m_last_o,
	input logic m_ready_i
);

	logic has_room;
	logic accept;
	logic prm_ren;
	logic [$clog2(MAX_CHN_N)-1:0] prm_raddr;
	bn_act_pkg::bn_param_t prm_rdata;
	logic fifo_wen;
	bn_act_pkg::fifo_entry_t fifo_wdata;

	bn_calc_pipe #(
		.MAX_CHN_N(MAX_CHN_N)
	) bn_calc_pipe_inst (
		.aclk(aclk),
		.rst_n_i(rst_n_i),
		.bn_accrc_i(bn_accrc_i),
		.bn_a_eq_1_i(bn_a_eq_1_i),
		.bn_b_eq_0_i(bn_b_eq_0_i),
		.s_valid_i(s_valid_i),
		.s_data_i(s_data_i),
		.s_chn_i(s_chn_i),
		.s_last_i(s_last_i),
		.s_ready_o(s_ready_o),
		.has_room_i(has_room),
		.accept_o(accept),
		.prm_ren_o(prm_ren),
		.prm_raddr_o(prm_raddr),
		.prm_rdata_i(prm_rdata),
		.fifo_wen_o(fifo_wen),
		.fifo_wdata_o(fifo_wdata)
	);

	// per-channel {B, A} table
	sdp_ram #(
		.elem_t(bn_act_pkg::bn_param_t),
		.DEPTH(MAX_CHN_N)
	) prm_ram_inst (
		.aclk(aclk),
		.wen_i(bn_wen_i),
		.waddr_i(bn_waddr_i),
		.wdata_i(bn_wdata_i),
		.ren_i(prm_ren),
		.raddr_i(prm_raddr),
		.rdata_o(prm_rdata)
	);

	res_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) res_fifo_inst (
		.aclk(aclk),
		.rst_n_i(rst_n_i),
		.accept_i(accept),
		.has_room_o(has_room),
		.wen_i(fifo_wen),
		.wdata_i(fifo_wdata),
		.m_valid_o(m_valid_o),
		.m_data_o(m_data_o),
		.m_last_o(m_last_o),
		.m_ready_i(m_ready_i)
	);

endmodule

// ==== verilog/bn_calc_pipe.sv ====
////////////////////////////////////////
// y = ((x * A) >>> accrc) + B, low 32 bits kept
// fixed latency, never stalls, so s_ready_o only follows FIFO room
// bn_accrc_i and the two flags must be static while items are in flight
////////////////////////////////////////
`timescale 1ns/1ps

module bn_calc_pipe #(
	parameter int MAX_CHN_N = 1024 // parameter table depth
)(
	input logic aclk,
	input logic rst_n_i,

	// static configuration
	input logic [bn_act_pkg::ACCRC_W-1:0] bn_accrc_i,
	input logic bn_a_eq_1_i,
	input logic bn_b_eq_0_i,

	// input stream
	input logic s_valid_i,
	input bn_act_pkg::data_t s_data_i,
	input logic [bn_act_pkg::CHN_W-1:0] s_chn_i,
	input logic s_last_i,
	output logic s_ready_o,

	// FIFO reservation
	input logic has_room_i,
	output logic accept_o,

	// parameter table read port
	output logic prm_ren_o,
	output logic [$clog2(MAX_CHN_N)-1:0] prm_raddr_o,
	input bn_act_pkg::bn_param_t prm_rdata_i,

	// FIFO write
	output logic fifo_wen_o,
	output bn_act_pkg::fifo_entry_t fifo_wdata_o
);

	localparam int LAT = bn_act_pkg::PIPE_LAT;
	localparam int PW = bn_act_pkg::PROD_W;
	localparam int DW = bn_act_pkg::DATA_W;

	logic [LAT-1:0] vld_q; // bit k is valid of stage k
	bn_act_pkg::data_t val_q0;
	logic last_q0;
	logic last_q1;
	logic last_q2;
	logic signed [PW-1:0] prod_q1;
	logic signed [PW-1:0] prod_q2;
	bn_act_pkg::data_t b_q1;
	bn_act_pkg::data_t b_q2;
	logic signed [PW-1:0] shifted;

	assign s_ready_o = has_room_i;
	assign accept_o = s_valid_i & has_room_i;

	// table read goes out with the transfer, pair returns for stage 1
	assign prm_ren_o = accept_o;
	assign prm_raddr_o = s_chn_i[$clog2(MAX_CHN_N)-1:0];

	always_ff @(posedge aclk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			vld_q <= '0;
		else
			vld_q <= {vld_q[LAT-2:0], accept_o};
	end

	// stage 0
	always_ff @(posedge aclk)
	begin
		if (accept_o)
		begin
			val_q0 <= s_data_i;
			last_q0 <= s_last_i;
		end
	end

	// stage 1 multiplies, or passes x when A is one
	always_ff @(posedge aclk)
	begin
		if (vld_q[0])
		begin
			if (bn_a_eq_1_i)
				prod_q1 <= PW'(val_q0);
			else
				prod_q1 <= PW'(val_q0) * PW'(prm_rdata_i.a);
			b_q1 <= bn_b_eq_0_i ? '0 : prm_rdata_i.b;
			last_q1 <= last_q0;
		end
	end

	// stage 2 retimes the product
	always_ff @(posedge aclk)
	begin
		if (vld_q[1])
		begin
			prod_q2 <= prod_q1;
			b_q2 <= b_q1;
			last_q2 <= last_q1;
		end
	end

	// arithmetic shift keeps the sign of the product
	assign shifted = bn_a_eq_1_i ? prod_q2 : (prod_q2 >>> bn_accrc_i);

	// stage 3
	always_ff @(posedge aclk)
	begin
		if (vld_q[2])
		begin
			fifo_wdata_o.data <= shifted[DW-1:0] + b_q2; // wraps to 32 bits
			fifo_wdata_o.last <= last_q2;
		end
	end

	assign fifo_wen_o = vld_q[LAT-1];

endmodule

// ==== verilog/res_fifo.sv ====
////////////////////////////////////////
// FIFO_DEPTH must be a power of two
// room is reserved at input acceptance, so writes never overflow
// RAM output register plus m_data_o form a two-word prefetch
////////////////////////////////////////
`timescale 1ns/1ps

module res_fifo #(
	parameter int FIFO_DEPTH = 16
)(
	input logic aclk,
	input logic rst_n_i,

	// reservation
	input logic accept_i,
	output logic has_room_o,

	// write side
	input logic wen_i,
	input bn_act_pkg::fifo_entry_t wdata_i,

	// output stream
	output logic m_valid_o,
	output bn_act_pkg::data_t m_data_o,
	output logic m_last_o,
	input logic m_ready_i
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_CNT = FIFO_DEPTH[AW:0];

	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0] stored_cnt; // words held in the RAM array
	logic [AW:0] credit_cnt; // accepted but not yet popped
	logic ren;
	logic rd_vld; // RAM output register holds a word
	logic out_load;
	logic pop;
	bn_act_pkg::fifo_entry_t rdata;

	assign pop = m_valid_o & m_ready_i;
	assign out_load = rd_vld & (~m_valid_o | m_ready_i);
	assign ren = (stored_cnt != '0) & (~rd_vld | out_load);
	assign has_room_o = credit_cnt < FULL_CNT;

	sdp_ram #(
		.elem_t(bn_act_pkg::fifo_entry_t),
		.DEPTH(FIFO_DEPTH)
	) store_ram_inst (
		.aclk(aclk),
		.wen_i(wen_i),
		.waddr_i(wptr),
		.wdata_i(wdata_i),
		.ren_i(ren),
		.raddr_i(rptr),
		.rdata_o(rdata)
	);

	always_ff @(posedge aclk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			credit_cnt <= '0;
		else if (accept_i & ~pop)
			credit_cnt <= credit_cnt + 1'b1;
		else if (pop & ~accept_i)
			credit_cnt <= credit_cnt - 1'b1;
	end

	always_ff @(posedge aclk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wptr <= '0;
			rptr <= '0;
			stored_cnt <= '0;
		end
		else
		begin
			if (wen_i)
				wptr <= wptr + 1'b1; // wraps at FIFO_DEPTH
			if (ren)
				rptr <= rptr + 1'b1;
			if (wen_i & ~ren)
				stored_cnt <= stored_cnt + 1'b1;
			else if (ren & ~wen_i)
				stored_cnt <= stored_cnt - 1'b1;
		end
	end

	always_ff @(posedge aclk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_vld <= 1'b0;
			m_valid_o <= 1'b0;
		end
		else
		begin
			if (ren)
				rd_vld <= 1'b1;
			else if (out_load)
				rd_vld <= 1'b0;

			if (out_load)
				m_valid_o <= 1'b1;
			else if (pop)
				m_valid_o <= 1'b0;
		end
	end

	// output payload changes only on a load, so held data stays stable
	always_ff @(posedge aclk)
	begin
		if (out_load)
		begin
			m_data_o <= rdata.data;
			m_last_o <= rdata.last;
		end
	end

endmodule

// ==== verilog/sdp_ram.sv ====
////////////////////////////////////////
// one write port, one registered read port
// rdata_o holds its value while ren_i is low
// DEPTH should be a power of two
////////////////////////////////////////
`timescale 1ns/1ps

module sdp_ram #(
	parameter type elem_t = logic [31:0],
	parameter int DEPTH = 16
)(
	input logic aclk,

	// port A
	input logic wen_i,
	input logic [$clog2(DEPTH)-1:0] waddr_i,
	input elem_t wdata_i,

	// port B
	input logic ren_i,
	input logic [$clog2(DEPTH)-1:0] raddr_i,
	output elem_t rdata_o
);

	elem_t mem [DEPTH];

	always_ff @(posedge aclk)
	begin
		if (wen_i)
			mem[waddr_i] <= wdata_i;
	end

	// one cycle read latency
	always_ff @(posedge aclk)
	begin
		if (ren_i)
			rdata_o <= mem[raddr_i];
	end

endmodule
